// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage;
    import exec_pkg::*;

    localparam int    MUL_CYCLES = 5;
    localparam int    DIV_CYCLES = 10;
    localparam int    BUSY_LIMIT = 40;
    localparam int    RESET_LIMIT = 50;
    localparam word_t IDLE_PC = 32'h0000_1000;

    logic        clk;
    logic        rst;
    fwd_sel_t    fwd_a;
    fwd_sel_t    fwd_b;
    opnd_sel_t   sel_a;
    opnd_sel_t   sel_b;
    alu_op_t     alu_op;
    md_op_t      md_op;
    logic        md_start;
    res_sel_t    res_sel;
    mem_kind_t   mem_kind;
    word_t       rf_a;
    word_t       rf_b;
    word_t       imm;
    word_t       m_pc8;
    word_t       m_result;
    word_t       w_result;
    word_t       pc;
    logic        in_delay;
    logic        unknown_instr;
    logic        trap_ovf;
    logic        cp0_we;
    cp0_addr_t   cp0_addr;
    logic        eret;
    logic [5:0]  hw_int;
    word_t       result;
    word_t       store_data;
    logic        busy;
    logic        exc_taken;
    logic        exc_return;
    word_t       target;

    int          errors = 0;
    int          timeouts = 0;
    logic [15:0] lfsr = 16'd27179;

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    exec_stage #(
        .MUL_CYCLES (MUL_CYCLES),
        .DIV_CYCLES (DIV_CYCLES)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .sel_a         (sel_a),
        .sel_b         (sel_b),
        .alu_op        (alu_op),
        .md_op         (md_op),
        .md_start      (md_start),
        .res_sel       (res_sel),
        .mem_kind      (mem_kind),
        .rf_a          (rf_a),
        .rf_b          (rf_b),
        .imm           (imm),
        .m_pc8         (m_pc8),
        .m_result      (m_result),
        .w_result      (w_result),
        .pc            (pc),
        .in_delay      (in_delay),
        .unknown_instr (unknown_instr),
        .trap_ovf      (trap_ovf),
        .cp0_we        (cp0_we),
        .cp0_addr      (cp0_addr),
        .eret          (eret),
        .hw_int        (hw_int),
        .result        (result),
        .store_data    (store_data),
        .busy          (busy),
        .exc_taken     (exc_taken),
        .exc_return    (exc_return),
        .target        (target)
    );

    // Taps 16, 14, 13 and 11 give a maximal length sequence.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD, ALU_ADDU: return a + b;
            ALU_SUB, ALU_SUBU: return a - b;
            ALU_AND:           return a & b;
            ALU_OR:            return a | b;
            ALU_XOR:           return a ^ b;
            ALU_NOR:           return ~(a | b);
            ALU_SLT:           return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:          return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:           return b << a[4:0];
            ALU_SRL:           return b >> a[4:0];
            ALU_SRA:           return word_t'($signed(b) >>> a[4:0]);
            ALU_LUI:           return {b[15:0], 16'h0000};
            default:           return '0;
        endcase
    endfunction

    function automatic word_t fwd_model(input fwd_sel_t sel, input word_t rf_val);
        case (sel)
            FWD_WB:      return w_result;
            FWD_MEM:     return m_result;
            FWD_MEM_PC8: return m_pc8;
            default:     return rf_val;
        endcase
    endfunction

    function automatic word_t opnd_model(input opnd_sel_t sel, input word_t fwd_val);
        case (sel)
            OPND_REG: return fwd_val;
            OPND_IMM: return imm;
            default:  return '0;
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_code(input exc_code_t got, input exc_code_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got code %0d, expected code %0d",
                     $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic set_idle();
        fwd_a         <= FWD_RF;
        fwd_b         <= FWD_RF;
        sel_a         <= OPND_REG;
        sel_b         <= OPND_REG;
        alu_op        <= ALU_ADDU;
        md_op         <= MD_MULT;
        md_start      <= 1'b0;
        res_sel       <= RES_ALU;
        mem_kind      <= MEM_NONE;
        rf_a          <= '0;
        rf_b          <= '0;
        imm           <= '0;
        m_pc8         <= '0;
        m_result      <= '0;
        w_result      <= '0;
        pc            <= IDLE_PC;
        in_delay      <= 1'b0;
        unknown_instr <= 1'b0;
        trap_ovf      <= 1'b0;
        cp0_we        <= 1'b0;
        cp0_addr      <= '0;
        eret          <= 1'b0;
        hw_int        <= '0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset was still asserted after %0d cycles", n);
            timeouts++;
        end
    endtask

    task automatic read_back(input res_sel_t sel, input cp0_addr_t addr, output word_t value);
        @(posedge clk);
        set_idle();
        res_sel  <= sel;
        cp0_addr <= addr;
        @(negedge clk);
        value = result;
    endtask

    task automatic cp0_write(input cp0_addr_t addr, input word_t value);
        @(posedge clk);
        set_idle();
        cp0_we   <= 1'b1;
        cp0_addr <= addr;
        rf_b     <= value;
    endtask

    task automatic reset_state();
        word_t v;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(exc_taken, 1'b0, "exc_taken after reset");
        check_bit(exc_return, 1'b0, "exc_return after reset");
        read_back(RES_CP0, CP0_SR, v);
        check_word(v, '0, "SR after reset");
        read_back(RES_HI, '0, v);
        check_word(v, '0, "HI after reset");
        read_back(RES_LO, '0, v);
        check_word(v, '0, "LO after reset");
        read_back(RES_CP0, CP0_PRID, v);
        check_word(v, PRID_VALUE, "PRId");
    endtask

    // Every forwarding source and operand choice, for every ALU operation.
    task automatic alu_sweep();
        word_t ea;
        word_t eb;
        for (int fa = 0; fa < 4; fa++) begin
            for (int fb = 0; fb < 4; fb++) begin
                for (int sa = 0; sa < 3; sa++) begin
                    for (int sb = 0; sb < 3; sb++) begin
                        for (int op = 0; op < 14; op++) begin
                            @(posedge clk);
                            set_idle();
                            fwd_a    <= fwd_sel_t'(fa);
                            fwd_b    <= fwd_sel_t'(fb);
                            sel_a    <= opnd_sel_t'(sa);
                            sel_b    <= opnd_sel_t'(sb);
                            alu_op   <= alu_op_t'(op);
                            rf_a     <= rand_word();
                            rf_b     <= rand_word();
                            imm      <= rand_word();
                            m_pc8    <= rand_word();
                            m_result <= rand_word();
                            w_result <= rand_word();
                            @(negedge clk);
                            ea = opnd_model(sel_a, fwd_model(fwd_a, rf_a));
                            eb = opnd_model(sel_b, fwd_model(fwd_b, rf_b));
                            check_word(result, alu_model(alu_op, ea, eb),
                                       $sformatf("ALU %s result", alu_op.name()));
                            check_word(store_data, fwd_model(fwd_b, rf_b), "store data");
                        end
                    end
                end
            end
        end
    endtask

    // The data address is a + b through the ALU.
    task automatic trigger_exc(input word_t pc_v, input word_t a, input word_t b,
                               input alu_op_t op, input logic trap, input mem_kind_t kind,
                               input logic unk, input logic delay, input exc_code_t exp);
        word_t v;
        @(posedge clk);
        set_idle();
        pc            <= pc_v;
        rf_a          <= a;
        rf_b          <= b;
        alu_op        <= op;
        trap_ovf      <= trap;
        mem_kind      <= kind;
        unknown_instr <= unk;
        in_delay      <= delay;
        @(negedge clk);
        if (exp == EXC_NONE) begin
            check_bit(exc_taken, 1'b0, "no exception expected");
        end else begin
            check_bit(exc_taken, 1'b1, "exception expected");
            check_word(target, EXC_VECTOR, "exception target");
            read_back(RES_CP0, CP0_CAUSE, v);
            check_code(exc_code_t'(v[6:2]), exp, "Cause code");
            check_bit(v[31], delay, "Cause branch-delay bit");
            read_back(RES_CP0, CP0_EPC, v);
            check_word(v, delay ? pc_v - 32'd4 : pc_v, "EPC");
        end
    endtask

    task automatic overflow_cases();
        trigger_exc(IDLE_PC, 32'h7fff_ffff, 32'h1, ALU_ADD, 1'b1, MEM_NONE, 1'b0, 1'b0, EXC_OV);
        trigger_exc(IDLE_PC, 32'h8000_0000, 32'h1, ALU_SUB, 1'b1, MEM_NONE, 1'b0, 1'b0, EXC_OV);
        trigger_exc(IDLE_PC, 32'h7fff_ffff, 32'h1, ALU_ADDU, 1'b0, MEM_NONE, 1'b0, 1'b0,
                    EXC_NONE);
        trigger_exc(IDLE_PC, 32'd5, 32'd6, ALU_ADD, 1'b1, MEM_NONE, 1'b0, 1'b0, EXC_NONE);
    endtask

    task automatic address_cases();
        trigger_exc(32'h0000_1002, '0, '0, ALU_ADDU, 1'b0, MEM_NONE, 1'b0, 1'b0, EXC_ADEL);
        trigger_exc(32'h0000_1001, '0, '0, ALU_ADDU, 1'b0, MEM_NONE, 1'b1, 1'b0, EXC_ADEL);
        trigger_exc(IDLE_PC, 32'h2000, 32'd2, ALU_ADDU, 1'b0, MEM_LW, 1'b0, 1'b0, EXC_ADEL);
        trigger_exc(IDLE_PC, 32'h2000, 32'd1, ALU_ADDU, 1'b0, MEM_LH, 1'b0, 1'b0, EXC_ADEL);
        trigger_exc(IDLE_PC, 32'h2000, 32'd2, ALU_ADDU, 1'b0, MEM_LH, 1'b0, 1'b0, EXC_NONE);
        trigger_exc(IDLE_PC, 32'h2000, 32'd1, ALU_ADDU, 1'b0, MEM_SW, 1'b0, 1'b0, EXC_ADES);
        trigger_exc(IDLE_PC, 32'h2000, 32'd3, ALU_ADDU, 1'b0, MEM_SH, 1'b0, 1'b0, EXC_ADES);
        trigger_exc(IDLE_PC, '0, '0, ALU_ADDU, 1'b0, MEM_NONE, 1'b1, 1'b0, EXC_RI);
        trigger_exc(32'h0000_1010, '0, '0, ALU_ADDU, 1'b0, MEM_NONE, 1'b1, 1'b1, EXC_RI);
    endtask

    task automatic md_model(input md_op_t op, input word_t a, input word_t b,
                            output word_t hi_exp, output word_t lo_exp);
        logic signed [63:0] sp;
        logic [63:0]        up;
        int                 sa;
        int                 sb;
        sa = a;
        sb = b;
        hi_exp = '0;
        lo_exp = '0;
        case (op)
            MD_MULT: begin
                sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                hi_exp = sp[63:32];
                lo_exp = sp[31:0];
            end
            MD_MULTU: begin
                up = {32'h0, a} * {32'h0, b};
                hi_exp = up[63:32];
                lo_exp = up[31:0];
            end
            MD_DIV: begin
                hi_exp = word_t'(sa % sb);
                lo_exp = word_t'(sa / sb);
            end
            MD_DIVU: begin
                hi_exp = a % b;
                lo_exp = a / b;
            end
            default: ;
        endcase
    endtask

    task automatic start_md(input md_op_t op, input word_t a, input word_t b);
        @(posedge clk);
        set_idle();
        md_op    <= op;
        md_start <= 1'b1;
        rf_a     <= a;
        rf_b     <= b;
        @(posedge clk);
        set_idle();
    endtask

    task automatic wait_idle(input int cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < BUSY_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (busy) begin
            $display("Timeout: multiply/divide unit still busy after %0d cycles at %0t ns",
                     n, $time);
            timeouts++;
        end else begin
            check_word(word_t'(n), word_t'(cycles), "busy length in cycles");
        end
    endtask

    task automatic md_check(input md_op_t op, input word_t a, input word_t b);
        word_t hi_exp;
        word_t lo_exp;
        word_t v;
        md_model(op, a, b, hi_exp, lo_exp);
        start_md(op, a, b);
        if (op == MD_DIV || op == MD_DIVU) begin
            wait_idle(DIV_CYCLES);
        end else begin
            wait_idle(MUL_CYCLES);
        end
        read_back(RES_HI, '0, v);
        check_word(v, hi_exp, $sformatf("HI after %s", op.name()));
        read_back(RES_LO, '0, v);
        check_word(v, lo_exp, $sformatf("LO after %s", op.name()));
    endtask

    task automatic move_to(input md_op_t op, input word_t value);
        @(posedge clk);
        set_idle();
        md_op    <= op;
        md_start <= 1'b1;
        rf_a     <= value;
        @(posedge clk);
        set_idle();
        res_sel <= (op == MD_MTHI) ? RES_HI : RES_LO;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after a move to HI or LO");
        check_word(result, value, $sformatf("value after %s", op.name()));
    endtask

    task automatic muldiv_cases();
        word_t a;
        word_t b;
        word_t v;
        for (int i = 0; i < 4; i++) begin
            a = rand_word();
            b = rand_word();
            md_check(MD_MULT, a, b);
            md_check(MD_MULTU, a, b);
            md_check(MD_DIV, a, b);
            md_check(MD_DIVU, a, b);
        end
        md_check(MD_MULT, 32'hffff_fffe, 32'd3);
        md_check(MD_DIV, 32'hffff_fff9, 32'd2);
        md_check(MD_DIVU, 32'hffff_fff9, 32'd2);
        move_to(MD_MTHI, 32'h1234_5678);
        move_to(MD_MTLO, 32'h9abc_def0);
        start_md(MD_DIV, 32'd77, '0);
        wait_idle(DIV_CYCLES);
        read_back(RES_HI, '0, v);
        check_word(v, 32'h1234_5678, "HI after divide by zero");
        read_back(RES_LO, '0, v);
        check_word(v, 32'h9abc_def0, "LO after divide by zero");
    endtask

    // SR value 0x401 unmasks hw_int[0] and sets the interrupt enable.
    task automatic interrupt_cases();
        word_t v;
        cp0_write(CP0_SR, 32'h0000_0401);
        read_back(RES_CP0, CP0_SR, v);
        check_word(v, 32'h0000_0401, "SR after write");
        @(posedge clk);
        set_idle();
        hw_int <= 6'b000010;
        @(negedge clk);
        check_bit(exc_taken, 1'b0, "masked interrupt");
        @(posedge clk);
        set_idle();
        hw_int <= 6'b000001;
        pc     <= 32'h0000_1200;
        @(negedge clk);
        check_bit(exc_taken, 1'b1, "unmasked interrupt");
        check_word(target, EXC_VECTOR, "interrupt target");
        @(posedge clk);
        set_idle();
        hw_int <= 6'b000001;
        @(negedge clk);
        check_bit(exc_taken, 1'b0, "interrupt at exception level");
        read_back(RES_CP0, CP0_CAUSE, v);
        check_code(exc_code_t'(v[6:2]), EXC_INT, "Cause code for interrupt");
        check_word(v & 32'h0000_fc00, 32'h0000_0400, "Cause pending interrupts");
        read_back(RES_CP0, CP0_EPC, v);
        check_word(v, 32'h0000_1200, "EPC after interrupt");
        read_back(RES_CP0, CP0_SR, v);
        check_word(v, 32'h0000_0403, "SR at exception level");
        @(posedge clk);
        set_idle();
        eret <= 1'b1;
        @(negedge clk);
        check_bit(exc_return, 1'b1, "exception return");
        check_bit(exc_taken, 1'b0, "no exception on return");
        check_word(target, 32'h0000_1200, "return target");
        read_back(RES_CP0, CP0_SR, v);
        check_word(v, 32'h0000_0401, "SR after return");
    endtask

    initial begin
        set_idle();
        wait_reset();
        reset_state();
        alu_sweep();
        overflow_cases();
        muldiv_cases();
        address_cases();
        interrupt_cases();
        $display("Checks done: %0d wrong values, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_exec_stage \
    -Mdir obj_dir -o sim_exec_stage
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_exec_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

// File: verilog.f
verilog/exec_pkg.sv
verilog/alu.sv
verilog/mult_div.sv
verilog/exc_judge.sv
verilog/cp0.sv
verilog/exec_stage.sv
bench/clock_gen.sv
bench/tb_exec_stage.sv

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::alu_op_t op,
    output exec_pkg::word_t   y,
    output logic              overflow
);
    import exec_pkg::*;

    logic [32:0] sum_ext;
    logic [32:0] diff_ext;

    // One extra sign bit makes signed overflow visible as a mismatch of the top two bits.
    assign sum_ext  = {a[31], a} + {b[31], b};
    assign diff_ext = {a[31], a} - {b[31], b};

    always_comb begin
        overflow = 1'b0;
        if (op == ALU_ADD) begin
            overflow = sum_ext[32] ^ sum_ext[31];
        end else if (op == ALU_SUB) begin
            overflow = diff_ext[32] ^ diff_ext[31];
        end
    end

    // Shift amount comes in on a, the value to shift on b.
    always_comb begin
        case (op)
            ALU_ADD, ALU_ADDU: y = sum_ext[31:0];
            ALU_SUB, ALU_SUBU: y = diff_ext[31:0];
            ALU_AND:           y = a & b;
            ALU_OR:            y = a | b;
            ALU_XOR:           y = a ^ b;
            ALU_NOR:           y = ~(a | b);
            ALU_SLT:           y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:          y = {31'b0, a < b};
            ALU_SLL:           y = b << a[4:0];
            ALU_SRL:           y = b >> a[4:0];
            ALU_SRA:           y = $signed(b) >>> a[4:0];
            ALU_LUI:           y = {b[15:0], 16'b0};
            default:           y = '0;
        endcase
    end

endmodule

// File: verilog/cp0.sv
`timescale 1ns/1ps

module cp0 (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::word_t     pc,
    input  logic                in_delay,
    input  exec_pkg::exc_code_t exc_code,
    input  logic [5:0]          hw_int,
    input  logic                we,
    input  exec_pkg::cp0_addr_t addr,
    input  exec_pkg::word_t     wdata,
    input  logic                eret,
    output exec_pkg::word_t     rdata,
    output logic                exc_taken,
    output logic                exc_return,
    output exec_pkg::word_t     target
);
    import exec_pkg::*;

    logic [5:0] sr_im;
    logic       sr_exl;
    logic       sr_ie;
    logic       cause_bd;
    logic [5:0] cause_ip;
    exc_code_t  cause_code;
    word_t      epc;
    logic       int_pending;
    exc_code_t  taken_code;

    // Interrupts are held off while exception level is set.
    assign int_pending = sr_ie && !sr_exl && |(hw_int & sr_im);
    assign taken_code  = int_pending ? EXC_INT : exc_code;
    assign exc_taken   = int_pending || (exc_code != EXC_NONE);
    assign exc_return  = eret && !exc_taken;
    assign target      = exc_taken ? EXC_VECTOR : epc;

    always_comb begin
        case (addr)
            CP0_SR:    rdata = {16'b0, sr_im, 8'b0, sr_exl, sr_ie};
            CP0_CAUSE: rdata = {cause_bd, 15'b0, cause_ip, 3'b0, cause_code, 2'b0};
            CP0_EPC:   rdata = epc;
            CP0_PRID:  rdata = PRID_VALUE;
            default:   rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sr_im      <= '0;
            sr_exl     <= 1'b0;
            sr_ie      <= 1'b0;
            cause_bd   <= 1'b0;
            cause_ip   <= '0;
            cause_code <= EXC_INT;
            epc        <= '0;
        end else if (exc_taken) begin
            // A delay-slot instruction restarts at its branch.
            epc        <= in_delay ? pc - 32'd4 : pc;
            cause_bd   <= in_delay;
            cause_ip   <= hw_int & sr_im;
            cause_code <= taken_code;
            sr_exl     <= 1'b1;
        end else if (exc_return) begin
            sr_exl <= 1'b0;
        end else if (we) begin
            if (addr == CP0_SR) begin
                sr_im  <= wdata[15:10];
                sr_exl <= wdata[1];
                sr_ie  <= wdata[0];
            end else if (addr == CP0_EPC) begin
                epc <= wdata;
            end
        end
    end

endmodule

// File: verilog/exc_judge.sv
`timescale 1ns/1ps

module exc_judge (
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     addr,
    input  exec_pkg::mem_kind_t mem_kind,
    input  logic                unknown_instr,
    input  logic                trap_ovf,
    input  logic                overflow,
    output exec_pkg::exc_code_t exc_code
);
    import exec_pkg::*;

    logic pc_bad;
    logic load_bad;
    logic store_bad;

    assign pc_bad    = (pc[1:0] != 2'b00);
    assign load_bad  = ((mem_kind == MEM_LW) && (addr[1:0] != 2'b00)) ||
                       ((mem_kind == MEM_LH) && addr[0]);
    assign store_bad = ((mem_kind == MEM_SW) && (addr[1:0] != 2'b00)) ||
                       ((mem_kind == MEM_SH) && addr[0]);

    // Fetch errors come first, data address errors last.
    always_comb begin
        if (pc_bad) begin
            exc_code = EXC_ADEL;
        end else if (unknown_instr) begin
            exc_code = EXC_RI;
        end else if (trap_ovf && overflow) begin
            exc_code = EXC_OV;
        end else if (load_bad) begin
            exc_code = EXC_ADEL;
        end else if (store_bad) begin
            exc_code = EXC_ADES;
        end else begin
            exc_code = EXC_NONE;
        end
    end

endmodule

// File: verilog/exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] word_t;

    typedef logic [4:0] cp0_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU,
        MD_MTHI,
        MD_MTLO
    } md_op_t;

    // The hazard unit uses this encoding and picks the memory-stage link value with 3.
    typedef enum logic [1:0] {
        FWD_RF      = 2'd0,
        FWD_WB      = 2'd1,
        FWD_MEM     = 2'd2,
        FWD_MEM_PC8 = 2'd3
    } fwd_sel_t;

    typedef enum logic [1:0] {
        OPND_REG  = 2'd0,
        OPND_IMM  = 2'd1,
        OPND_ZERO = 2'd2
    } opnd_sel_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_HI,
        RES_LO,
        RES_CP0
    } res_sel_t;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LH,
        MEM_SW,
        MEM_SH
    } mem_kind_t;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_NONE = 5'd31
    } exc_code_t;

    localparam cp0_addr_t CP0_SR    = 5'd12;
    localparam cp0_addr_t CP0_CAUSE = 5'd13;
    localparam cp0_addr_t CP0_EPC   = 5'd14;
    localparam cp0_addr_t CP0_PRID  = 5'd15;

    localparam word_t EXC_VECTOR = 32'h0000_4180;
    localparam word_t PRID_VALUE = 32'h0001_8a01;

endpackage

// File: verilog/exec_stage.sv
`timescale 1ns/1ps

module exec_stage #(
    parameter int MUL_CYCLES = 5,
    parameter int DIV_CYCLES = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::fwd_sel_t  fwd_a,
    input  exec_pkg::fwd_sel_t  fwd_b,
    input  exec_pkg::opnd_sel_t sel_a,
    input  exec_pkg::opnd_sel_t sel_b,
    input  exec_pkg::alu_op_t   alu_op,
    input  exec_pkg::md_op_t    md_op,
    input  logic                md_start,
    input  exec_pkg::res_sel_t  res_sel,
    input  exec_pkg::mem_kind_t mem_kind,
    input  exec_pkg::word_t     rf_a,
    input  exec_pkg::word_t     rf_b,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     m_pc8,
    input  exec_pkg::word_t     m_result,
    input  exec_pkg::word_t     w_result,
    input  exec_pkg::word_t     pc,
    input  logic                in_delay,
    input  logic                unknown_instr,
    input  logic                trap_ovf,
    input  logic                cp0_we,
    input  exec_pkg::cp0_addr_t cp0_addr,
    input  logic                eret,
    input  logic [5:0]          hw_int,
    output exec_pkg::word_t     result,
    output exec_pkg::word_t     store_data,
    output logic                busy,
    output logic                exc_taken,
    output logic                exc_return,
    output exec_pkg::word_t     target
);
    import exec_pkg::*;

    word_t     fa;
    word_t     fb;
    word_t     opnd_a;
    word_t     opnd_b;
    word_t     alu_y;
    logic      alu_ovf;
    word_t     hi;
    word_t     lo;
    word_t     cp0_rdata;
    exc_code_t exc_code;

    function automatic word_t pick_fwd(
        input fwd_sel_t sel,
        input word_t    rf_val,
        input word_t    w_val,
        input word_t    m_val,
        input word_t    pc8_val
    );
        case (sel)
            FWD_WB:      return w_val;
            FWD_MEM:     return m_val;
            FWD_MEM_PC8: return pc8_val;
            default:     return rf_val;
        endcase
    endfunction

    function automatic word_t pick_opnd(
        input opnd_sel_t sel,
        input word_t     fwd_val,
        input word_t     imm_val
    );
        case (sel)
            OPND_REG: return fwd_val;
            OPND_IMM: return imm_val;
            default:  return '0;
        endcase
    endfunction

    assign fa         = pick_fwd(fwd_a, rf_a, w_result, m_result, m_pc8);
    assign fb         = pick_fwd(fwd_b, rf_b, w_result, m_result, m_pc8);
    assign opnd_a     = pick_opnd(sel_a, fa, imm);
    assign opnd_b     = pick_opnd(sel_b, fb, imm);
    assign store_data = fb;

    always_comb begin
        case (res_sel)
            RES_HI:  result = hi;
            RES_LO:  result = lo;
            RES_CP0: result = cp0_rdata;
            default: result = alu_y;
        endcase
    end

    alu u_alu (
        .a        (opnd_a),
        .b        (opnd_b),
        .op       (alu_op),
        .y        (alu_y),
        .overflow (alu_ovf)
    );

    // Multiply and divide always take the forwarded registers, never the immediate.
    mult_div #(
        .MUL_CYCLES (MUL_CYCLES),
        .DIV_CYCLES (DIV_CYCLES)
    ) u_mult_div (
        .clk   (clk),
        .rst   (rst),
        .start (md_start),
        .op    (md_op),
        .a     (fa),
        .b     (fb),
        .busy  (busy),
        .hi    (hi),
        .lo    (lo)
    );

    exc_judge u_exc_judge (
        .pc            (pc),
        .addr          (alu_y),
        .mem_kind      (mem_kind),
        .unknown_instr (unknown_instr),
        .trap_ovf      (trap_ovf),
        .overflow      (alu_ovf),
        .exc_code      (exc_code)
    );

    cp0 u_cp0 (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .in_delay   (in_delay),
        .exc_code   (exc_code),
        .hw_int     (hw_int),
        .we         (cp0_we),
        .addr       (cp0_addr),
        .wdata      (fb),
        .eret       (eret),
        .rdata      (cp0_rdata),
        .exc_taken  (exc_taken),
        .exc_return (exc_return),
        .target     (target)
    );

endmodule

// File: verilog/mult_div.sv
`timescale 1ns/1ps

module mult_div #(
    parameter int MUL_CYCLES = 5,
    parameter int DIV_CYCLES = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  exec_pkg::md_op_t op,
    input  exec_pkg::word_t  a,
    input  exec_pkg::word_t  b,
    output logic             busy,
    output exec_pkg::word_t  hi,
    output exec_pkg::word_t  lo
);
    import exec_pkg::*;

    typedef enum logic {ST_IDLE, ST_RUN} md_state_t;

    localparam int MAX_CYCLES = (MUL_CYCLES > DIV_CYCLES) ? MUL_CYCLES : DIV_CYCLES;
    localparam int CW = $clog2(MAX_CYCLES + 1);

    md_state_t   state;
    logic [CW-1:0] count;
    md_op_t      op_r;
    word_t       a_r;
    word_t       b_r;
    logic        is_signed;
    logic        is_div;
    logic [63:0] prod;
    word_t       abs_a;
    word_t       abs_b;
    word_t       uq;
    word_t       ur;
    word_t       quot;
    word_t       rem;

    assign busy      = (state == ST_RUN);
    assign is_div    = (op_r == MD_DIV) || (op_r == MD_DIVU);
    assign is_signed = (op_r == MD_MULT) || (op_r == MD_DIV);

    // Signed division runs on magnitudes, then the signs are put back.
    always_comb begin
        if (is_signed) begin
            prod = $signed(a_r) * $signed(b_r);
        end else begin
            prod = a_r * b_r;
        end
        abs_a = (is_signed && a_r[31]) ? -a_r : a_r;
        abs_b = (is_signed && b_r[31]) ? -b_r : b_r;
        uq    = (abs_b == '0) ? '0 : abs_a / abs_b;
        ur    = (abs_b == '0) ? '0 : abs_a % abs_b;
        quot  = (is_signed && (a_r[31] ^ b_r[31])) ? -uq : uq;
        rem   = (is_signed && a_r[31]) ? -ur : ur;
    end

    always_ff @(posedge clk) begin
        if (start && state == ST_IDLE) begin
            op_r <= op;
            a_r  <= a;
            b_r  <= b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            count <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        case (op)
                            MD_MTHI: hi <= a;
                            MD_MTLO: lo <= a;
                            MD_DIV, MD_DIVU: begin
                                state <= ST_RUN;
                                count <= CW'(DIV_CYCLES - 1);
                            end
                            default: begin
                                state <= ST_RUN;
                                count <= CW'(MUL_CYCLES - 1);
                            end
                        endcase
                    end
                end
                ST_RUN: begin
                    if (count == '0) begin
                        state <= ST_IDLE;
                        if (!is_div) begin
                            hi <= prod[63:32];
                            lo <= prod[31:0];
                        end else if (b_r != '0) begin
                            // Divide by zero keeps the old HI and LO.
                            hi <= rem;
                            lo <= quot;
                        end
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule
